//--- src.f
+incdir+logic
logic/dcache_pkg.sv
logic/mem_bus_pkg.sv
logic/data_cache_word_block.sv
logic/data_cache_qword_block.sv
logic/dcache_ctrl.sv
logic/mem_arbiter.sv
logic/main_memory.sv
logic/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

export_include_dirs:
  - logic

sources:
  - files:
      - logic/dcache_pkg.sv
      - logic/mem_bus_pkg.sv
      - logic/data_cache_word_block.sv
      - logic/data_cache_qword_block.sv
      - logic/dcache_ctrl.sv
      - logic/mem_arbiter.sv
      - logic/main_memory.sv
      - logic/dcache_top.sv
  - target: test
    files:
      - verification/dcache_checker.sv
      - verification/dcache_tb.sv

//--- verification/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tb;

   localparam int AW          = `DCACHE_ADDR_WIDTH;
   localparam int WORDS       = 2 ** AW;
   localparam int PASS_CYCLES = `DCACHE_LINES * 12 + 64;

   // Table entry kinds
   localparam int K_READ     = 0;
   localparam int K_WRITE    = 1;
   localparam int K_SYNC     = 2;
   localparam int K_DMA      = 3;
   localparam int K_SYNC_DMA = 4;

   logic                  clk_i = 1'b0;
   logic                  rst_i;
   logic                  sync;
   dcache_pkg::line_idx_t cpu_raddr;
   logic [AW-1:0]         cpu_waddr;
   logic [31:0]           cpu_wdata;
   logic [3:0]            cpu_be;
   logic                  dma_req;
   logic [AW-1:0]         dma_addr;
   logic [31:0]           dma_wdata;
   logic [31:0]           rdata [4];
   logic                  busy;
   logic                  stall;
   logic                  dma_gnt;

   // Reference model state
   logic [31:0] sh_mem [WORDS];
   logic [31:0] sh_cache [WORDS];
   logic        sh_dirty [`DCACHE_LINES];

   int            tab_kind [$];
   logic [AW-1:0] tab_addr [$];
   logic [31:0]   tab_data [$];
   logic [3:0]    tab_be [$];

   int checks = 0;
   int errors = 0;
   int cycle_cnt = 0;
   int cycle_limit = 0;

   always #2 clk_i = ~clk_i;

   dcache_top dcache_top_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .sync_i      (sync),
      .cpu_raddr_i (cpu_raddr),
      .cpu_waddr_i (cpu_waddr),
      .cpu_wdata_i (cpu_wdata),
      .cpu_be_i    (cpu_be),
      .dma_req_i   (dma_req),
      .dma_addr_i  (dma_addr),
      .dma_wdata_i (dma_wdata),
      .cpu_rdata0_o(rdata[0]),
      .cpu_rdata1_o(rdata[1]),
      .cpu_rdata2_o(rdata[2]),
      .cpu_rdata3_o(rdata[3]),
      .busy_o      (busy),
      .stall_o     (stall),
      .dma_gnt_o   (dma_gnt)
   );

   ////////////////////
   // Helpers
   ////////////////////

   task automatic add_entry(input int kind, input logic [AW-1:0] addr,
                            input logic [31:0] data, input logic [3:0] be);
      tab_kind.push_back(kind);
      tab_addr.push_back(addr);
      tab_data.push_back(data);
      tab_be.push_back(be);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy && n < 2 * PASS_CYCLES) begin
         @(negedge clk_i);
         n++;
      end
      if (busy) begin
         errors++;
         $display("busy_o still high %0d cycles into a sync pass", n);
      end
   endtask

   // Write-back then reload of every dirty line, in index order
   function automatic void model_sync(input bit with_dma, input logic [AW-1:0] addr,
                                      input logic [31:0] data);
      int base;
      bit hit;
      for (int l = 0; l < `DCACHE_LINES; l++) begin
         if (sh_dirty[l]) begin
            base = l * 4;
            hit  = with_dma && (addr[AW-1:2] == l);
            for (int w = 0; w < 4; w++) begin
               sh_mem[base + w] = sh_cache[base + w];
            end
            // Alternating grants slot a DMA write between write-back and read-back
            if (hit) begin
               sh_mem[addr] = data;
            end
            for (int w = 0; w < 4; w++) begin
               sh_cache[base + w] = sh_mem[base + w];
            end
            sh_dirty[l] = hit;
         end
      end
      if (with_dma) begin
         sh_mem[addr] = data;
      end
   endfunction

   task automatic read_line(input int line);
      cpu_raddr = dcache_pkg::line_idx_t'(line);
      @(negedge clk_i);
      check_value("stall_o", stall, 32'd0);
      for (int w = 0; w < 4; w++) begin
         check_value($sformatf("cpu_rdata%0d_o (line %0d)", w, line), rdata[w],
                     sh_cache[line * 4 + w]);
      end
   endtask

   task automatic write_word(input logic [AW-1:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
      cpu_waddr = addr;
      cpu_wdata = data;
      cpu_be    = be;
      @(negedge clk_i);
      cpu_be = 4'b0000;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            sh_cache[addr][8*b +: 8] = data[8*b +: 8];
         end
      end
      if (be != 4'b0000) begin
         sh_dirty[addr[AW-1:2]] = 1'b1;
      end
   endtask

   task automatic dma_write(input logic [AW-1:0] addr, input logic [31:0] data);
      bit granted;
      int n;
      granted   = 1'b0;
      n         = 0;
      dma_addr  = addr;
      dma_wdata = data;
      dma_req   = 1'b1;
      while (!granted && n < 4) begin
         #1;
         granted = dma_gnt;
         @(negedge clk_i);
         n++;
      end
      dma_req = 1'b0;
      if (granted) begin
         sh_mem[addr] = data;
      end else begin
         errors++;
         $display("Idle DMA write to address %0d was never granted", addr);
      end
   endtask

   // Sync pulse, optionally with back-to-back DMA writes for the whole pass
   task automatic run_sync(input bit with_dma, input logic [AW-1:0] addr,
                           input logic [31:0] data);
      bit granted;
      int waits;
      granted = 1'b0;
      waits   = 0;
      sync    = 1'b1;
      @(negedge clk_i);
      sync = 1'b0;
      if (!busy) begin
         errors++;
         $display("busy_o did not rise after the sync pulse");
      end
      check_value("stall_o", stall, 32'd1);
      if (with_dma) begin
         dma_addr  = addr;
         dma_wdata = data;
         dma_req   = 1'b1;
         while (busy && waits < 2) begin
            #1;
            granted = dma_gnt;
            @(negedge clk_i);
            waits = granted ? 0 : waits + 1;
         end
         dma_req = 1'b0;
         if (waits > 1) begin
            errors++;
            $display("DMA request waited more than one cycle for a grant during a pass");
         end else if (!granted) begin
            errors++;
            $display("DMA request still waiting for a grant when busy_o fell");
         end
      end
      wait_idle();
      model_sync(with_dma, addr, data);
   endtask

   task automatic build_table();
      // Reset fill
      for (int l = 0; l < `DCACHE_LINES; l++) begin
         add_entry(K_READ, AW'(l * 4), '0, '0);
      end
      // Byte-enabled writes
      add_entry(K_WRITE, 5'd6, $urandom, 4'b0011);
      add_entry(K_WRITE, 5'd12, $urandom, 4'b1111);
      add_entry(K_WRITE, 5'd15, $urandom, 4'b0100);
      add_entry(K_READ, 5'd4, '0, '0);
      add_entry(K_READ, 5'd12, '0, '0);
      add_entry(K_SYNC, '0, '0, '0);
      for (int l = 0; l < `DCACHE_LINES; l++) begin
         add_entry(K_READ, AW'(l * 4), '0, '0);
      end
      // Idle DMA into a clean line
      add_entry(K_DMA, 5'd21, $urandom, '0);
      add_entry(K_READ, 5'd20, '0, '0);
      add_entry(K_WRITE, 5'd22, $urandom, 4'b1000);
      add_entry(K_SYNC, '0, '0, '0);
      add_entry(K_READ, 5'd20, '0, '0);
      // DMA into a dirty line while it syncs
      add_entry(K_WRITE, 5'd1, $urandom, 4'b1111);
      add_entry(K_SYNC_DMA, 5'd2, $urandom, '0);
      add_entry(K_READ, 5'd0, '0, '0);
      add_entry(K_SYNC, '0, '0, '0);
      add_entry(K_READ, 5'd0, '0, '0);
      // DMA stream into a clean line
      add_entry(K_SYNC_DMA, 5'd27, $urandom, '0);
      add_entry(K_READ, 5'd24, '0, '0);
      add_entry(K_WRITE, 5'd24, $urandom, 4'b0001);
      add_entry(K_SYNC, '0, '0, '0);
      add_entry(K_READ, 5'd24, '0, '0);
   endtask

   ////////////////////
   // Watchdog
   ////////////////////

   initial begin
      wait (cycle_limit > 0);
      while (cycle_cnt < cycle_limit) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, the stimulus table did not finish", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      void'($urandom(10670));
      rst_i     = 1'b1;
      sync      = 1'b0;
      cpu_raddr = '0;
      cpu_waddr = '0;
      cpu_wdata = '0;
      cpu_be    = 4'b0000;
      dma_req   = 1'b0;
      dma_addr  = '0;
      dma_wdata = '0;
      for (int i = 0; i < WORDS; i++) begin
         sh_mem[i] = 32'(i);
      end
      build_table();
      cycle_limit = (tab_kind.size() + 2) * 2 * PASS_CYCLES;
      repeat (5) @(negedge clk_i);
      rst_i = 1'b0;
      wait_idle();
      // Fill pass leaves every line clean with the memory contents
      for (int i = 0; i < WORDS; i++) begin
         sh_cache[i] = sh_mem[i];
      end
      for (int l = 0; l < `DCACHE_LINES; l++) begin
         sh_dirty[l] = 1'b0;
      end
      for (int i = 0; i < tab_kind.size(); i++) begin
         case (tab_kind[i])
            K_READ:     read_line(int'(tab_addr[i][AW-1:2]));
            K_WRITE:    write_word(tab_addr[i], tab_data[i], tab_be[i]);
            K_SYNC:     run_sync(1'b0, tab_addr[i], tab_data[i]);
            K_DMA:      dma_write(tab_addr[i], tab_data[i]);
            K_SYNC_DMA: run_sync(1'b1, tab_addr[i], tab_data[i]);
            default: begin
               errors++;
               $display("Unknown table entry kind %0d", tab_kind[i]);
            end
         endcase
      end
      $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
               dcache_top_inst.ctrl_inst.checker_inst.fail_count);
      if (errors == 0 && dcache_top_inst.ctrl_inst.checker_inst.fail_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- verification/dcache_checker.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_checker (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  dcache_pkg::sync_state_t     state_i,
   input  logic                        req_i,
   input  mem_bus_pkg::mem_op_t        op_i,
   input  logic [`DCACHE_ADDR_WIDTH-1:0] addr_i,
   input  logic                        ctrl_gnt_i,
   input  logic                        dma_gnt_i,
   input  dcache_pkg::line_idx_t       line_i,
   input  logic [`DCACHE_LINES-1:0]    dirty_i,
   input  logic [`DCACHE_LINES-1:0]    flushing_n_i
);

   localparam int LINES = `DCACHE_LINES;

   int fail_count = 0;

   logic [LINES-1:0] flush_edge;

   // Low bit with a high neighbour below it, bit 0 sees a high floor
   assign flush_edge = ~flushing_n_i & {flushing_n_i[LINES-2:0], 1'b1};

   // Controller waits only behind a DMA grant, and one cycle at most
   grant_rr: assert property (@(posedge clk_i) disable iff (rst_i)
      (req_i && !ctrl_gnt_i) |-> dma_gnt_i ##1 ctrl_gnt_i)
      else begin
         fail_count++;
         $error("controller request not granted on the following cycle");
      end

   // Back-pressure keeps the request and its address on the bus
   req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (req_i && !ctrl_gnt_i) |=> req_i && $stable(op_i) && $stable(addr_i))
      else begin
         fail_count++;
         $error("controller request dropped or changed while waiting for a grant");
      end

   // LOAD updates exactly the current line, and only a dirty one
   flush_line: assert property (@(posedge clk_i) disable iff (rst_i)
      (state_i == dcache_pkg::LOAD) |->
         dirty_i[line_i] && (flush_edge == (LINES'(1) << line_i)))
      else begin
         fail_count++;
         $error("flush vector does not select the dirty line in LOAD");
      end

endmodule

// DMA grant reaches the controller as its hit strobe
bind dcache_ctrl dcache_checker checker_inst (
   .clk_i       (clk_i),
   .rst_i       (rst_i),
   .state_i     (state),
   .req_i       (req_o),
   .op_i        (op_o),
   .addr_i      (addr_o),
   .ctrl_gnt_i  (gnt_i),
   .dma_gnt_i   (dma_hit_i),
   .line_i      (line),
   .dirty_i     (dirty_i),
   .flushing_n_i(flushing_n_o)
);

//--- logic/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            sync_i,
   input  dcache_pkg::line_idx_t           cpu_raddr_i,
   input  logic [`DCACHE_ADDR_WIDTH-1:0]   cpu_waddr_i,
   input  logic [31:0]                     cpu_wdata_i,
   input  logic [3:0]                      cpu_be_i,
   input  logic                            dma_req_i,
   input  logic [`DCACHE_ADDR_WIDTH-1:0]   dma_addr_i,
   input  logic [31:0]                     dma_wdata_i,
   output logic [31:0]                     cpu_rdata0_o,
   output logic [31:0]                     cpu_rdata1_o,
   output logic [31:0]                     cpu_rdata2_o,
   output logic [31:0]                     cpu_rdata3_o,
   output logic                            busy_o,
   output logic                            stall_o,
   output logic                            dma_gnt_o
);

   logic                                  ctrl_req;
   logic                                  ctrl_gnt;
   mem_bus_pkg::mem_op_t                  ctrl_op;
   logic [`DCACHE_ADDR_WIDTH-1:0]         ctrl_addr;
   logic [31:0]                           ctrl_wdata;
   logic                                  mem_we;
   logic [`DCACHE_ADDR_WIDTH-1:0]         mem_addr;
   logic [31:0]                           mem_wdata;
   logic [31:0]                           mem_rdata;
   logic                                  dma_hit;
   logic [`DCACHE_ADDR_WIDTH-3:0]         dma_line;
   logic [`DCACHE_LINES-1:0]              dirty;
   dcache_pkg::line_idx_t                 rd_line;
   dcache_pkg::line_idx_t                 cache_raddr;
   logic [3:0]                            cache_be;
   logic [32*`DCACHE_WORDS_PER_LINE-1:0]  flush_data;
   logic [`DCACHE_LINES-1:0]              flushing_n;
   logic                                  cleaned_n;

   assign stall_o = busy_o;

   // Controller owns the cache read port during a pass, CPU writes drop
   assign cache_raddr = busy_o ? rd_line : cpu_raddr_i;
   assign cache_be    = stall_o ? 4'b0000 : cpu_be_i;

   data_cache_qword_block cache_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .addr_r_i    (cache_raddr),
      .addr_w_i    (cpu_waddr_i),
      .data_i      (cpu_wdata_i),
      .write_en_i  (cache_be),
      .flush_data_i(flush_data),
      .flushing_n_i(flushing_n),
      .cleaned_n_i (cleaned_n),
      .data0_o     (cpu_rdata0_o),
      .data1_o     (cpu_rdata1_o),
      .data2_o     (cpu_rdata2_o),
      .data3_o     (cpu_rdata3_o),
      .dirty_o     (dirty)
   );

   dcache_ctrl ctrl_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .sync_i      (sync_i),
      .dirty_i     (dirty),
      .line_data_i ({cpu_rdata3_o, cpu_rdata2_o, cpu_rdata1_o, cpu_rdata0_o}),
      .gnt_i       (ctrl_gnt),
      .mem_rdata_i (mem_rdata),
      .dma_hit_i   (dma_hit),
      .dma_line_i  (dma_line),
      .busy_o      (busy_o),
      .req_o       (ctrl_req),
      .op_o        (ctrl_op),
      .addr_o      (ctrl_addr),
      .wdata_o     (ctrl_wdata),
      .rd_line_o   (rd_line),
      .flush_data_o(flush_data),
      .flushing_n_o(flushing_n),
      .cleaned_n_o (cleaned_n)
   );

   mem_arbiter arbiter_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ctrl_req_i  (ctrl_req),
      .ctrl_op_i   (ctrl_op),
      .ctrl_addr_i (ctrl_addr),
      .ctrl_wdata_i(ctrl_wdata),
      .dma_req_i   (dma_req_i),
      .dma_addr_i  (dma_addr_i),
      .dma_wdata_i (dma_wdata_i),
      .ctrl_gnt_o  (ctrl_gnt),
      .dma_gnt_o   (dma_gnt_o),
      .mem_we_o    (mem_we),
      .mem_addr_o  (mem_addr),
      .mem_wdata_o (mem_wdata),
      .dma_hit_o   (dma_hit),
      .dma_line_o  (dma_line)
   );

   main_memory memory_inst (
      .clk_i  (clk_i),
      .we_i   (mem_we),
      .addr_i (mem_addr),
      .wdata_i(mem_wdata),
      .rdata_o(mem_rdata)
   );

endmodule

//--- logic/main_memory.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module main_memory (
   input  logic                            clk_i,
   input  logic                            we_i,
   input  logic [`DCACHE_ADDR_WIDTH-1:0]   addr_i,
   input  logic [31:0]                     wdata_i,
   output logic [31:0]                     rdata_o
);

   localparam int DEPTH = 2 ** `DCACHE_ADDR_WIDTH;
   localparam int LAT   = `DCACHE_MEM_LATENCY;

   logic [31:0] mem [DEPTH];
   logic [31:0] rd_pipe [LAT];

   // Each word starts out holding its own address
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = 32'(i);
      end
   end

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[addr_i] <= wdata_i;
      end
   end

   // Read pipeline, depth set by the memory latency
   always_ff @(posedge clk_i) begin
      rd_pipe[0] <= mem[addr_i];
      for (int i = 1; i < LAT; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign rdata_o = rd_pipe[LAT-1];

endmodule

//--- logic/mem_arbiter.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module mem_arbiter (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            ctrl_req_i,
   input  mem_bus_pkg::mem_op_t            ctrl_op_i,
   input  logic [`DCACHE_ADDR_WIDTH-1:0]   ctrl_addr_i,
   input  logic [31:0]                     ctrl_wdata_i,
   input  logic                            dma_req_i,
   input  logic [`DCACHE_ADDR_WIDTH-1:0]   dma_addr_i,
   input  logic [31:0]                     dma_wdata_i,
   output logic                            ctrl_gnt_o,
   output logic                            dma_gnt_o,
   output logic                            mem_we_o,
   output logic [`DCACHE_ADDR_WIDTH-1:0]   mem_addr_o,
   output logic [31:0]                     mem_wdata_o,
   output logic                            dma_hit_o,
   output logic [`DCACHE_ADDR_WIDTH-3:0]   dma_line_o
);

   mem_bus_pkg::requester_t last_owner;

   // Round robin, the peer that went last yields on contention
   assign ctrl_gnt_o = ctrl_req_i & (!dma_req_i | (last_owner == mem_bus_pkg::REQ_DMA));
   assign dma_gnt_o  = dma_req_i & (!ctrl_req_i | (last_owner == mem_bus_pkg::REQ_CTRL));

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         last_owner <= mem_bus_pkg::REQ_DMA;
      end else if (ctrl_gnt_o) begin
         last_owner <= mem_bus_pkg::REQ_CTRL;
      end else if (dma_gnt_o) begin
         last_owner <= mem_bus_pkg::REQ_DMA;
      end
   end

   ////////////////////
   // Memory side mux
   ////////////////////

   // DMA only ever writes
   assign mem_we_o    = dma_gnt_o | (ctrl_gnt_o & (ctrl_op_i == mem_bus_pkg::MEM_WRITE));
   assign mem_addr_o  = dma_gnt_o ? dma_addr_i : ctrl_addr_i;
   assign mem_wdata_o = dma_gnt_o ? dma_wdata_i : ctrl_wdata_i;

   // Tells the controller which line the DMA touched
   assign dma_hit_o   = dma_gnt_o;
   assign dma_line_o  = dma_addr_i[`DCACHE_ADDR_WIDTH-1:2];

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_ctrl (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic                                  sync_i,
   input  logic [`DCACHE_LINES-1:0]              dirty_i,
   input  logic [32*`DCACHE_WORDS_PER_LINE-1:0]  line_data_i,
   input  logic                                  gnt_i,
   input  logic [31:0]                           mem_rdata_i,
   input  logic                                  dma_hit_i,
   input  dcache_pkg::line_idx_t                 dma_line_i,
   output logic                                  busy_o,
   output logic                                  req_o,
   output mem_bus_pkg::mem_op_t                  op_o,
   output logic [`DCACHE_ADDR_WIDTH-1:0]         addr_o,
   output logic [31:0]                           wdata_o,
   output dcache_pkg::line_idx_t                 rd_line_o,
   output logic [32*`DCACHE_WORDS_PER_LINE-1:0]  flush_data_o,
   output logic [`DCACHE_LINES-1:0]              flushing_n_o,
   output logic                                  cleaned_n_o
);

   localparam int LAT = `DCACHE_MEM_LATENCY;

   dcache_pkg::sync_state_t                state;
   dcache_pkg::line_idx_t                  line;
   logic [2:0]                             word_cnt;
   logic [1:0]                             cap_cnt;
   logic [LAT-1:0]                         rd_pend;
   logic                                   collide;
   logic                                   fill;
   logic                                   rd_issue;
   logic                                   line_hit;
   logic                                   last_line;
   logic [32*`DCACHE_WORDS_PER_LINE-1:0]   flush_data;

   assign rd_issue  = (state == dcache_pkg::RD_WORD) && req_o && gnt_i;
   assign line_hit  = dma_hit_i && (dma_line_i == line);
   assign last_line = (line == dcache_pkg::line_idx_t'(`DCACHE_LINES - 1));

   ////////////////////
   // Pass sequencer
   ////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         // Fill pass starts straight out of reset
         state    <= dcache_pkg::SCAN;
         line     <= '0;
         word_cnt <= '0;
         cap_cnt  <= '0;
         rd_pend  <= '0;
         collide  <= 1'b0;
         fill     <= 1'b1;
      end else begin
         rd_pend <= (rd_pend << 1) | LAT'(rd_issue);
         if (rd_pend[LAT-1]) begin
            cap_cnt <= cap_cnt + 2'd1;
         end
         case (state)
            dcache_pkg::IDLE: begin
               if (sync_i) begin
                  state <= dcache_pkg::SCAN;
                  line  <= '0;
               end
            end
            dcache_pkg::SCAN: begin
               word_cnt <= '0;
               collide  <= 1'b0;
               if (!dirty_i[line]) begin
                  state <= dcache_pkg::NEXT;
               end else if (fill) begin
                  // Nothing valid in the line yet, read it straight in
                  state <= dcache_pkg::RD_WORD;
               end else begin
                  state <= dcache_pkg::WB_WORD;
               end
            end
            dcache_pkg::WB_WORD: begin
               if (line_hit) begin
                  collide <= 1'b1;
               end
               if (gnt_i) begin
                  if (word_cnt[1:0] == 2'd3) begin
                     word_cnt <= '0;
                     state    <= dcache_pkg::RD_WORD;
                  end else begin
                     word_cnt <= word_cnt + 3'd1;
                  end
               end
            end
            dcache_pkg::RD_WORD: begin
               if (line_hit) begin
                  collide <= 1'b1;
               end
               if (rd_issue) begin
                  word_cnt <= word_cnt + 3'd1;
               end
               // Last read-back arriving ends the line
               if (rd_pend[LAT-1] && (cap_cnt == 2'd3)) begin
                  state <= dcache_pkg::LOAD;
               end
            end
            dcache_pkg::LOAD: begin
               state <= dcache_pkg::NEXT;
            end
            dcache_pkg::NEXT: begin
               if (last_line) begin
                  state <= dcache_pkg::IDLE;
                  fill  <= 1'b0;
               end else begin
                  line  <= line + 1'b1;
                  state <= dcache_pkg::SCAN;
               end
            end
            default: state <= dcache_pkg::IDLE;
         endcase
      end
   end

   // Read-backs land in order of issue
   always_ff @(posedge clk_i) begin
      if (rd_pend[LAT-1]) begin
         flush_data[cap_cnt*32 +: 32] <= mem_rdata_i;
      end
   end

   ////////////////////
   // Outputs
   ////////////////////

   assign busy_o       = (state != dcache_pkg::IDLE);
   assign req_o        = (state == dcache_pkg::WB_WORD) ||
                         ((state == dcache_pkg::RD_WORD) && !word_cnt[2]);
   assign op_o         = (state == dcache_pkg::WB_WORD) ? mem_bus_pkg::MEM_WRITE
                                                        : mem_bus_pkg::MEM_READ;
   assign addr_o       = {line, word_cnt[1:0]};
   assign wdata_o      = line_data_i[word_cnt[1:0]*32 +: 32];
   assign rd_line_o    = line;
   assign flush_data_o = flush_data;

   // A DMA write on the LOAD edge also counts as a collision
   assign cleaned_n_o  = collide | line_hit;

   // Current line and the ones above it held low during LOAD
   always_comb begin
      for (int i = 0; i < `DCACHE_LINES; i++) begin
         flushing_n_o[i] = !((state == dcache_pkg::LOAD) && (i >= line));
      end
   end

endmodule

//--- logic/data_cache_qword_block.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module data_cache_qword_block (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  dcache_pkg::line_idx_t                 addr_r_i,
   input  logic [`DCACHE_ADDR_WIDTH-1:0]         addr_w_i,
   input  logic [31:0]                           data_i,
   input  logic [3:0]                            write_en_i,
   input  logic [32*`DCACHE_WORDS_PER_LINE-1:0]  flush_data_i,
   input  logic [`DCACHE_LINES-1:0]              flushing_n_i,
   input  logic                                  cleaned_n_i,
   output logic [31:0]                           data0_o,
   output logic [31:0]                           data1_o,
   output logic [31:0]                           data2_o,
   output logic [31:0]                           data3_o,
   output logic [`DCACHE_LINES-1:0]              dirty_o
);

   localparam int LINES = `DCACHE_LINES;
   localparam int WORDS = `DCACHE_WORDS_PER_LINE;

   logic [LINES-1:0]      dirty;
   logic [LINES-1:0]      updating;
   logic [LINES-1:0]      word_flush_n;
   logic [31:0]           word_rdata [WORDS];
   dcache_pkg::line_idx_t line_w;
   logic [1:0]            sel_w;

   assign line_w = addr_w_i[`DCACHE_ADDR_WIDTH-1:2];
   assign sel_w  = addr_w_i[1:0];

   // Thermometer edge picks the single line being updated
   always_comb begin
      updating[0] = !flushing_n_i[0];
      for (int i = 1; i < LINES; i++) begin
         updating[i] = !flushing_n_i[i] & flushing_n_i[i-1];
      end
   end

   // Only dirty lines take the loaded data
   assign word_flush_n = ~(updating & dirty);

   ////////////////////
   // Word banks
   ////////////////////

   for (genvar w = 0; w < WORDS; w++) begin : g_bank
      logic [3:0] bank_be;

      assign bank_be = (sel_w == w) ? write_en_i : 4'b0000;

      data_cache_word_block #(
         .LINES(LINES)
      ) bank_inst (
         .clk_i       (clk_i),
         .addr_r_i    (addr_r_i),
         .addr_w_i    (line_w),
         .data_i      (data_i),
         .write_en_i  (bank_be),
         .flush_data_i(flush_data_i[32*w +: 32]),
         .flushing_n_i(word_flush_n),
         .data_o      (word_rdata[w])
      );
   end

   ////////////////////
   // Dirty tracking
   ////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dirty <= '1;
      end else begin
         for (int l = 0; l < LINES; l++) begin
            if (updating[l]) begin
               dirty[l] <= cleaned_n_i;
            end else if ((write_en_i != 4'b0000) && (line_w == l)) begin
               dirty[l] <= 1'b1;
            end
         end
      end
   end

   assign dirty_o = dirty;
   assign data0_o = word_rdata[0];
   assign data1_o = word_rdata[1];
   assign data2_o = word_rdata[2];
   assign data3_o = word_rdata[3];

endmodule

//--- logic/data_cache_word_block.sv
`timescale 1ns/1ps

module data_cache_word_block #(
   parameter int LINES = 8
) (
   input  logic                     clk_i,
   input  logic [$clog2(LINES)-1:0] addr_r_i,
   input  logic [$clog2(LINES)-1:0] addr_w_i,
   input  logic [31:0]              data_i,
   input  logic [3:0]               write_en_i,
   input  logic [31:0]              flush_data_i,
   input  logic [LINES-1:0]         flushing_n_i,
   output logic [31:0]              data_o
);

   // One word of every line
   logic [31:0] mem [LINES];

   always_ff @(posedge clk_i) begin
      for (int l = 0; l < LINES; l++) begin
         if (!flushing_n_i[l]) begin
            mem[l] <= flush_data_i;
         end else if (addr_w_i == l) begin
            // Byte lanes merge into the stored word
            for (int b = 0; b < 4; b++) begin
               if (write_en_i[b]) begin
                  mem[l][8*b +: 8] <= data_i[8*b +: 8];
               end
            end
         end
      end
   end

   // Registered read, one cycle
   always_ff @(posedge clk_i) begin
      data_o <= mem[addr_r_i];
   end

endmodule

//--- logic/mem_bus_pkg.sv
package mem_bus_pkg;

   ////////////////////
   // Shared memory bus
   ////////////////////

   // Operation carried with a request
   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_op_t;

   // Peer that owns (or last owned) the bus
   typedef enum logic {
      REQ_CTRL = 1'b0,
      REQ_DMA  = 1'b1
   } requester_t;

endpackage

//--- logic/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

   ////////////////////
   // Sync sequencer
   ////////////////////

   // Pass states of the write-back and fill controller
   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      SCAN    = 3'd1,
      WB_WORD = 3'd2,
      RD_WORD = 3'd3,
      LOAD    = 3'd4,
      NEXT    = 3'd5
   } sync_state_t;

   ////////////////////
   // Line addressing
   ////////////////////

   // Index of one cache line
   typedef logic [$clog2(`DCACHE_LINES)-1:0] line_idx_t;

endpackage

//--- logic/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

////////////////////
// Address space
////////////////////

// Word address width, covers the whole backing memory
`define DCACHE_ADDR_WIDTH 5

// Lines in the cache, 2 ** (DCACHE_ADDR_WIDTH - 2)
`define DCACHE_LINES 8

// Words per line, low two address bits pick the word
`define DCACHE_WORDS_PER_LINE 4

////////////////////
// Memory timing
////////////////////

// Cycles from a granted read to valid read data
`define DCACHE_MEM_LATENCY 1

`endif
